//--- dv/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk); // Four cycles in reset
    #1 rst_n = 1'b1;           // Released 1 ns after the edge like the stimulus
  end

endmodule

//--- dv/tb_hsi_mse.sv
`timescale 1ns/10ps

module tb_hsi_mse;
  import hsi_mse_pkg::*;
  import hsi_geom_pkg::*;

  typedef logic [HSI_BANDS-1:0][HM_DATA_WIDTH-1:0] pixel_t; // Band 0 low

  logic                               clk;
  logic                               rst_n;
  logic                               px_valid;
  logic [HSI_LANES*HM_DATA_WIDTH-1:0] px_ref;
  logic [HSI_LANES*HM_DATA_WIDTH-1:0] px_test;
  logic                               mse_valid;
  logic [HM_DATA_WIDTH_ACC-1:0]       mse;
  logic [HSI_PIX_WIDTH-1:0]           mse_pix;
  integer                             seed;
  logic [HSI_PIX_WIDTH-1:0]           pix_idx; // Next expected pixel number
  bit                                 ok;
  pixel_t                             ref_px;
  pixel_t                             test_px;

  tb_clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

  hsi_mse i_hsi_mse (
    .clk(clk), .rst_n(rst_n), .px_valid(px_valid), .px_ref(px_ref), .px_test(px_test),
    .mse_valid(mse_valid), .mse(mse), .mse_pix(mse_pix)
  );

  tb_mse_checker i_mse_checker (
    .clk(clk), .rst_n(rst_n), .px_valid(px_valid),
    .mse_valid(mse_valid), .mse(mse), .mse_pix(mse_pix)
  );

  // Sum of squared band errors over the pixel divided by the band count
  function automatic logic [HM_DATA_WIDTH_ACC-1:0] ref_mse(input pixel_t r, input pixel_t t);
    longint sum;
    longint d;
    sum = 0;
    for (int b = 0; b < HSI_BANDS; b++) begin
      d   = longint'($signed(r[b])) - longint'($signed(t[b]));
      sum = sum + d * d;
    end
    return HM_DATA_WIDTH_ACC'(sum >> HSI_BAND_SHIFT);
  endfunction

  task automatic idle(input int n);
    px_valid = 1'b0;
    repeat (n) begin
      px_ref  = {$random(seed), $random(seed)}; // Junk on the bus that the DUT must ignore
      px_test = {$random(seed), $random(seed)};
      @(posedge clk);
      #1;
    end
  endtask

  task automatic random_pixel(output pixel_t r, output pixel_t t);
    for (int b = 0; b < HSI_BANDS; b++) begin
      r[b] = $random(seed);
      t[b] = $random(seed);
    end
  endtask

  task automatic send_pixel(input string name, input pixel_t r, input pixel_t t,
                            input int max_gap);
    int gap;
    i_mse_checker.push_expected(name, ref_mse(r, t), pix_idx);
    pix_idx++;
    for (int b = 0; b < HSI_BEATS; b++) begin
      if (max_gap > 0) begin
        gap = {$random(seed)} % (max_gap + 1); // Gap before this beat
        idle(gap);
      end
      px_valid = 1'b1;
      px_ref   = r[b*HSI_LANES +: HSI_LANES];
      px_test  = t[b*HSI_LANES +: HSI_LANES];
      @(posedge clk);
      #1;
    end
    px_valid = 1'b0;
  endtask

  task automatic wait_reset(output bit done);
    int t;
    t = 0;
    while (rst_n !== 1'b1 && t < 50) begin
      @(posedge clk);
      t++;
    end
    done = (rst_n === 1'b1);
    if (!done) begin
      $display("timeout: reset was never released");
    end else begin
      @(posedge clk);
      #1;                       // Line up with the drive point
    end
  endtask

  task automatic wait_drain(output bit done);
    int t;
    t = 0;
    while (i_mse_checker.pending() > 0 && t < 200) begin
      @(posedge clk);
      #1;                       // Checker has finished with this edge
      t++;
    end
    done = (i_mse_checker.pending() == 0);
    if (!done) begin
      $display("timeout: %0d pixel results never arrived", i_mse_checker.pending());
    end
  endtask

  initial begin
    seed     = 32'h378;
    px_valid = 1'b0;
    px_ref   = '0;
    px_test  = '0;
    pix_idx  = '0;
    wait_reset(ok);
    if (ok) begin
      idle(8);                  // No result may appear before a full pixel
      for (int n = 0; n < 8; n++) begin
        random_pixel(ref_px, test_px);
        send_pixel("back_to_back", ref_px, test_px, 0);
      end
      idle(3);
      for (int n = 0; n < 8; n++) begin
        random_pixel(ref_px, test_px);
        send_pixel("gaps", ref_px, test_px, 3);
      end
      random_pixel(ref_px, test_px);
      send_pixel("identical", ref_px, ref_px, 0);
      ref_px  = {HSI_BANDS{16'h7fff}};
      test_px = {HSI_BANDS{16'h8000}};
      send_pixel("extreme", ref_px, test_px, 0);
      send_pixel("extreme_swapped", test_px, ref_px, 0);
      send_pixel("restart", ref_px, test_px, 0); // Large sum followed by a zero pixel
      send_pixel("restart", test_px, test_px, 0);
      wait_drain(ok);
      idle(8);                  // Catch stray pulses after the last pixel
    end
    i_mse_checker.report_counts();
    if (ok && i_mse_checker.error_total() == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- dv/tb_mse_checker.sv
`timescale 1ns/10ps

module tb_mse_checker (
  input logic                                     clk,
  input logic                                     rst_n,
  input logic                                     px_valid,
  input logic                                     mse_valid,
  input logic [hsi_mse_pkg::HM_DATA_WIDTH_ACC-1:0] mse,
  input logic [hsi_geom_pkg::HSI_PIX_WIDTH-1:0]   mse_pix
);
  import hsi_mse_pkg::*;
  import hsi_geom_pkg::*;

  logic [HM_DATA_WIDTH_ACC-1:0] exp_mse_q[$]; // One entry per pixel from the stimulus
  logic [HSI_PIX_WIDTH-1:0]     exp_pix_q[$];
  string                        name_q[$];
  longint                       due_q[$];     // Cycle each result must show up
  longint                       cyc = 0;
  int                           beat_n = 0;   // Own count of beats inside a pixel
  int                           checked_cnt = 0;
  int                           mismatch_cnt = 0;
  int                           other_cnt = 0;

  task automatic push_expected(input string name, input logic [HM_DATA_WIDTH_ACC-1:0] m,
                               input logic [HSI_PIX_WIDTH-1:0] p);
    name_q.push_back(name);
    exp_mse_q.push_back(m);
    exp_pix_q.push_back(p);
  endtask

  function automatic int pending();
    return exp_mse_q.size();
  endfunction

  function automatic int error_total();
    return mismatch_cnt + other_cnt;
  endfunction

  task automatic report_counts();
    $display("checked %0d results, %0d mismatches, %0d other errors",
             checked_cnt, mismatch_cnt, other_cnt);
  endtask

  task automatic compare_result();
    string                        name;
    logic [HM_DATA_WIDTH_ACC-1:0] em;
    logic [HSI_PIX_WIDTH-1:0]     ep;
    longint                       due;
    if (exp_mse_q.size() == 0 || due_q.size() == 0) begin
      other_cnt++;
      $display("mse_valid at cycle %0d while no complete pixel was outstanding", cyc);
    end else begin
      name = name_q.pop_front();
      em   = exp_mse_q.pop_front();
      ep   = exp_pix_q.pop_front();
      due  = due_q.pop_front();
      checked_cnt++;
      if (mse !== em) begin
        mismatch_cnt++;
        $display("mismatch %s mse expected %0d actual %0d", name, em, mse);
      end
      if (mse_pix !== ep) begin
        mismatch_cnt++;
        $display("mismatch %s mse_pix expected %0d actual %0d", name, ep, mse_pix);
      end
      if (cyc != due) begin
        mismatch_cnt++;
        $display("mismatch %s result cycle expected %0d actual %0d", name, due, cyc);
      end
    end
  endtask

  // Inputs settle 1 ns after the edge so the edge sees stable values
  always @(posedge clk) begin
    cyc++;
    if (!rst_n) begin
      beat_n = 0;
    end else begin
      if (px_valid === 1'b1) begin
        beat_n++;
        if (beat_n == HSI_BEATS) begin
          due_q.push_back(cyc + 4); // Lane pipe plus reduction register
          beat_n = 0;
        end
      end
      if (mse_valid === 1'b1) begin
        compare_result();
      end else if (mse_valid !== 1'b0) begin
        other_cnt++;
        $display("mse_valid is unknown at cycle %0d", cyc);
      end
    end
  end

endmodule

//--- hsi_mse.f
rtl/hsi_geom_pkg.sv
rtl/hsi_mse_pkg.sv
rtl/hm_acc_if.sv
rtl/sq_df_acc.sv
rtl/hm_beat_ctrl.sv
rtl/hm_mse_reduce.sv
rtl/hsi_mse.sv
dv/tb_clk_gen.sv
dv/tb_mse_checker.sv
dv/tb_hsi_mse.sv

//--- rtl/hm_acc_if.sv
`timescale 1ns/10ps

interface hm_acc_if;
  import hsi_mse_pkg::*;
  import hsi_geom_pkg::*;

  logic                                         acc_valid; // Lane 0 output strobe
  logic                                         acc_last;  // Beat closes a pixel
  logic [HSI_PIX_WIDTH-1:0]                     acc_pix;   // Pixel number of this beat
  logic [HSI_LANES-1:0][HM_DATA_WIDTH_ACC-1:0]  acc_data;  // Running sum per lane

  modport lanes (
    output acc_valid,
    output acc_data
  );

  modport ctrl (
    output acc_last,
    output acc_pix
  );

  modport reduce (
    input acc_valid,
    input acc_last,
    input acc_pix,
    input acc_data
  );

endinterface

//--- rtl/hm_beat_ctrl.sv
`timescale 1ns/10ps

module hm_beat_ctrl (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     px_valid,   // One beat of HSI_LANES samples
  output logic     first_beat, // Beat opens a pixel in the px_valid cycle
  hm_acc_if.ctrl   acc         // Framing aligned with lane outputs
);
  import hsi_geom_pkg::*;

  logic [$clog2(HSI_BEATS+1)-1:0]         beat_cnt;  // Beat position inside the pixel
  logic [HSI_PIX_WIDTH-1:0]               pix_cnt;   // Number of the pixel on the input
  logic                                   last_beat; // Beat closes a pixel
  logic [HSI_LATENCY-1:0]                 last_sr;   // Last flag delay line
  logic [HSI_LATENCY-1:0][HSI_PIX_WIDTH-1:0] pix_sr; // Pixel number delay line

  assign first_beat = px_valid && (beat_cnt == '0);
  assign last_beat  = px_valid && (beat_cnt == HSI_BEATS - 1);

  // Beat and pixel counters hold through gaps
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt <= '0;
      pix_cnt  <= '0;
    end else if (px_valid) begin
      if (last_beat) begin
        beat_cnt <= '0;              // Wrap for the next pixel
        pix_cnt  <= pix_cnt + 1'b1;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // Same depth as sq_df_acc so framing meets the lane sums
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_sr <= '0;
      pix_sr  <= '0;
    end else begin
      last_sr <= {last_sr[HSI_LATENCY-2:0], last_beat}; // Already gated by px_valid
      pix_sr  <= {pix_sr[HSI_LATENCY-2:0], pix_cnt};
    end
  end

  assign acc.acc_last = last_sr[HSI_LATENCY-1];
  assign acc.acc_pix  = pix_sr[HSI_LATENCY-1];

  a_cnt_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    beat_cnt < HSI_BEATS
  ) else $error("beat counter out of range");

endmodule

//--- rtl/hm_mse_reduce.sv
`timescale 1ns/10ps

module hm_mse_reduce (
  input  logic                                     clk,
  input  logic                                     rst_n,
  hm_acc_if.reduce                                 acc,
  output logic                                     mse_valid, // One pulse per pixel
  output logic [hsi_mse_pkg::HM_DATA_WIDTH_ACC-1:0] mse,      // Mean of squared errors
  output logic [hsi_geom_pkg::HSI_PIX_WIDTH-1:0]   mse_pix    // Pixel the mean belongs to
);
  import hsi_mse_pkg::*;
  import hsi_geom_pkg::*;

  logic [HM_SUM_WIDTH-1:0] lane_sum; // Widened so no carry is lost
  logic                    pix_done; // Lanes hold the complete pixel sums

  assign pix_done = acc.acc_valid & acc.acc_last;

  always_comb begin
    lane_sum = '0;
    for (int l = 0; l < HSI_LANES; l++) begin
      lane_sum = lane_sum + HM_SUM_WIDTH'(acc.acc_data[l]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mse_valid <= 1'b0;
    end else begin
      mse_valid <= pix_done;
    end
  end

  // Result word loads only on a pixel close
  always_ff @(posedge clk) begin
    if (pix_done) begin
      mse     <= HM_DATA_WIDTH_ACC'(lane_sum >> HSI_BAND_SHIFT); // Divide by HSI_BANDS
      mse_pix <= acc.acc_pix;
    end
  end

  // Framing from the controller must land on a lane output beat
  a_last_has_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    acc.acc_last |-> acc.acc_valid
  ) else $error("pixel close without lane data");

  // No lane may move its sum without the lane 0 strobe
  a_lanes_agree: assert property (
    @(posedge clk) disable iff (!rst_n)
    !acc.acc_valid |-> $stable(acc.acc_data)
  ) else $error("lane sum changed without lane 0 strobe");

endmodule

//--- rtl/hsi_geom_pkg.sv
package hsi_geom_pkg;

  localparam int HSI_BANDS      = 16;                    // Spectral samples per pixel
  localparam int HSI_LANES      = 4;                     // Samples per beat
  localparam int HSI_BEATS      = HSI_BANDS / HSI_LANES; // Beats per pixel
  localparam int HSI_BAND_SHIFT = $clog2(HSI_BANDS);     // Divide by band count

  // Pixel numbering wraps at 2**16
  localparam int HSI_PIX_WIDTH  = 16;

  // Depth of the per-lane difference, square, accumulate pipe
  localparam int HSI_LATENCY    = 3;

endpackage

//--- rtl/hsi_mse.sv
`timescale 1ns/10ps

module hsi_mse (
  input  logic                                     clk,
  input  logic                                     rst_n,

  input  logic                                     px_valid, // Beat strobe without back-pressure
  input  logic [hsi_geom_pkg::HSI_LANES*hsi_mse_pkg::HM_DATA_WIDTH-1:0] px_ref,  // Lane 0 low
  input  logic [hsi_geom_pkg::HSI_LANES*hsi_mse_pkg::HM_DATA_WIDTH-1:0] px_test, // Lane 0 low

  output logic                                     mse_valid,
  output logic [hsi_mse_pkg::HM_DATA_WIDTH_ACC-1:0] mse,
  output logic [hsi_geom_pkg::HSI_PIX_WIDTH-1:0]   mse_pix
);
  import hsi_mse_pkg::*;
  import hsi_geom_pkg::*;

  logic first_beat; // Restarts every lane sum

  hm_acc_if acc_if ();

  hm_beat_ctrl i_beat_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .px_valid   (px_valid),
    .first_beat (first_beat),
    .acc        (acc_if.ctrl)
  );

  for (genvar i = 0; i < HSI_LANES; i++) begin : g_lane
    logic lane_valid; // Identical in every lane

    sq_df_acc #(
      .DATA_WIDTH     (HM_DATA_WIDTH),
      .DATA_WIDTH_MUL (HM_DATA_WIDTH_MUL),
      .DATA_WIDTH_ACC (HM_DATA_WIDTH_ACC)
    ) i_sq_df_acc (
      .clk            (clk),
      .rst_n          (rst_n),
      .initial_acc_en (first_beat),
      .initial_acc    ('0),                                          // Each pixel starts at zero
      .data_in_valid  (px_valid),
      .data_in_v1     (px_ref[i*HM_DATA_WIDTH +: HM_DATA_WIDTH]),
      .data_in_v2     (px_test[i*HM_DATA_WIDTH +: HM_DATA_WIDTH]),
      .data_out_valid (lane_valid),
      .data_out       (acc_if.acc_data[i])
    );

    // One strobe is enough for the reduction
    if (i == 0) begin : g_strobe
      assign acc_if.acc_valid = lane_valid;
    end
  end

  hm_mse_reduce i_mse_reduce (
    .clk       (clk),
    .rst_n     (rst_n),
    .acc       (acc_if.reduce),
    .mse_valid (mse_valid),
    .mse       (mse),
    .mse_pix   (mse_pix)
  );

endmodule

//--- rtl/hsi_mse_pkg.sv
package hsi_mse_pkg;

  // Signed input sample
  localparam int HM_DATA_WIDTH     = 16;

  // Square of the 17-bit sample difference
  localparam int HM_DATA_WIDTH_MUL = 2 * (HM_DATA_WIDTH + 1);

  // Lane accumulator and final MSE word
  localparam int HM_DATA_WIDTH_ACC = 40;

  // Sum over all lanes grows by log2 of the lane count
  localparam int HM_SUM_WIDTH      = HM_DATA_WIDTH_ACC + $clog2(hsi_geom_pkg::HSI_LANES);

endpackage

//--- rtl/sq_df_acc.sv
`timescale 1ns/10ps

module sq_df_acc #(
  parameter int DATA_WIDTH     = hsi_mse_pkg::HM_DATA_WIDTH,     // Sample width
  parameter int DATA_WIDTH_MUL = hsi_mse_pkg::HM_DATA_WIDTH_MUL, // Square width
  parameter int DATA_WIDTH_ACC = hsi_mse_pkg::HM_DATA_WIDTH_ACC  // Running sum width
) (
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic                          initial_acc_en, // Restart sum on this beat
  input  logic [DATA_WIDTH_ACC-1:0]     initial_acc,    // Start value for the restart

  input  logic                          data_in_valid,
  input  logic signed [DATA_WIDTH-1:0]  data_in_v1,     // Reference sample
  input  logic signed [DATA_WIDTH-1:0]  data_in_v2,     // Test sample

  output logic                          data_out_valid,
  output logic [DATA_WIDTH_ACC-1:0]     data_out        // Running sum of squares
);

  logic                       en_1;       // Stage 1 holds a beat
  logic                       en_2;       // Stage 2 holds a beat
  logic                       init_1;     // Restart flag, stage 1
  logic                       init_2;     // Restart flag, stage 2
  logic [DATA_WIDTH_ACC-1:0]  init_val_1; // Start value, stage 1
  logic [DATA_WIDTH_ACC-1:0]  init_val_2; // Start value, stage 2
  logic signed [DATA_WIDTH:0] diff;       // One spare bit so full scale cannot wrap
  logic [DATA_WIDTH_MUL-1:0]  sq;         // Always non-negative

  // Strobes, restart flags and the running sum
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_1           <= 1'b0;
      en_2           <= 1'b0;
      init_1         <= 1'b0;
      init_2         <= 1'b0;
      data_out_valid <= 1'b0;
      data_out       <= '0;
    end else begin
      en_1           <= data_in_valid;
      init_1         <= data_in_valid & initial_acc_en; // Only a real beat restarts
      en_2           <= en_1;
      init_2         <= init_1;
      data_out_valid <= en_2;
      if (en_2) begin
        if (init_2) begin
          data_out <= init_val_2 + sq;  // First beat drops the old sum
        end else begin
          data_out <= data_out + sq;    // Keep adding within the pixel
        end
      end                               // Sum holds on idle cycles
    end
  end

  // Data path moves only with its strobe
  always_ff @(posedge clk) begin
    if (data_in_valid) begin
      diff       <= data_in_v1 - data_in_v2; // Stage 1
      init_val_1 <= initial_acc;
    end
    if (en_1) begin
      sq         <= diff * diff;             // Stage 2
      init_val_2 <= init_val_1;
    end
  end

  // Every output beat came from an input beat exactly three cycles back
  a_out_has_in: assert property (
    @(posedge clk) disable iff (!rst_n)
    data_out_valid |-> $past(data_in_valid, 3)
  ) else $error("sq_df_acc output without matching input");

endmodule
